/* flist.f */
+incdir+.
fm_pkg.sv
fm_timer_if.sv
fm_chan_if.sv
fm_mmr.sv
fm_timers.sv
fm_voice.sv
fm_mixer.sv
fm_top.sv
fm_props.sv
fm_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fm core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fm_tb -f flist.f -o fm_sim

./obj_dir/fm_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* fm_tb.sv */
`include "fm_consts.svh"

module fm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 8;
    localparam int NUM_WR      = 30;
    localparam int MARGIN      = 2000;          // clks on top of the windows
    localparam int REL_SMP     = 256 / 255 + 2; // release at rr = 255
    localparam int K_RESET     = 0;
    localparam int K_BUSY      = 1;
    localparam int K_TIMER     = 2;
    localparam int K_VOICE     = 3;             // keys stay on afterwards
    localparam int K_VOICE_OFF = 4;             // key off and wait for silence

    typedef struct packed {
        logic       poll;   // wait for busy low first
        logic [7:0] ra;
        logic [7:0] data;
    } wr_t;

    typedef struct packed {
        int         kind;
        int         first;  // first row in wr_tab
        int         num;
        logic [1:0] flags;  // dout[1:0] at the end of the window
        logic       irq;
        int         period; // cen ticks to the flag or 0 when none
        logic [1:0] act;    // {left, right} expected nonzero
        int         win;    // cen ticks allowed
    } test_t;

    logic               rst;
    logic               clk;
    logic               cen;
    logic [7:0]         din;
    logic [1:0]         addr;
    logic               cs_n;
    logic               wr_n;
    logic [7:0]         dout;
    logic               irq_n;
    logic signed [15:0] snd_left;
    logic signed [15:0] snd_right;
    logic               snd_sample;

    logic gated;            // random cen gaps in the timer tests
    int   ticks;
    int   errors;
    int   passed;
    int   cycles;
    int   limit;

    string names [NUM_TESTS] = '{"reset", "busy", "timer a", "timer b", "timer b no irq",
                                 "ch0 left", "ch2 right", "ch1 left + ch2 right"};

    test_t tests [NUM_TESTS] = '{
        '{K_RESET,      0, 0, 2'b00, 1'b1, 0,                               2'b00, 12},
        '{K_BUSY,       0, 1, 2'b00, 1'b1, 0,                               2'b00, 40},
        '{K_TIMER,      1, 5, 2'b01, 1'b0, (1024 - 10'h3e8) * `FM_NUM_CH,   2'b00, 120},
        '{K_TIMER,      6, 3, 2'b10, 1'b0, (256 - 8'hfe) * 16 * `FM_NUM_CH, 2'b00, 150},
        '{K_TIMER,      9, 3, 2'b00, 1'b1, 0,                               2'b00, 400},
        '{K_VOICE_OFF, 12, 6, 2'b00, 1'b1, 0,                               2'b10, 30},
        '{K_VOICE,     18, 6, 2'b00, 1'b1, 0,                               2'b01, 30},
        '{K_VOICE_OFF, 24, 6, 2'b00, 1'b1, 0,                               2'b11, 30}
    };

    wr_t wr_tab [NUM_WR] = '{
        '{1'b1, `FM_REG_TB,    8'h00},
        '{1'b1, `FM_REG_TCTL,  8'h30},  // stop both and clear flags
        '{1'b1, `FM_REG_TA_HI, 8'hfa},  // value_a 1000
        '{1'b0, `FM_REG_TA_HI, 8'h00},  // lands while busy and is dropped
        '{1'b1, `FM_REG_TA_LO, 8'h00},
        '{1'b1, `FM_REG_TCTL,  8'h05},  // load a with irq a
        '{1'b1, `FM_REG_TCTL,  8'h30},
        '{1'b1, `FM_REG_TB,    8'hfe},
        '{1'b1, `FM_REG_TCTL,  8'h0a},  // load b with irq b
        '{1'b1, `FM_REG_TCTL,  8'h30},
        '{1'b1, `FM_REG_TB,    8'hfe},
        '{1'b1, `FM_REG_TCTL,  8'h02},  // load b only
        '{1'b1, `FM_REG_FNUM_LO, 8'h00},
        '{1'b1, `FM_REG_FNUM_HI, 8'h01},
        '{1'b1, `FM_REG_AR,      8'hff},
        '{1'b1, `FM_REG_RR,      8'hff},
        '{1'b1, `FM_REG_PAN,     8'h80},
        '{1'b1, `FM_REG_KEYON,   8'h10},
        '{1'b1, `FM_REG_FNUM_LO + 8'd2, 8'h40},
        '{1'b1, `FM_REG_FNUM_HI + 8'd2, 8'h02},
        '{1'b1, `FM_REG_AR + 8'd2,      8'hff},
        '{1'b1, `FM_REG_RR + 8'd2,      8'hff},
        '{1'b1, `FM_REG_PAN + 8'd2,     8'h40},
        '{1'b1, `FM_REG_KEYON,          8'h12},
        '{1'b1, `FM_REG_FNUM_LO + 8'd1, 8'h80},
        '{1'b1, `FM_REG_FNUM_HI + 8'd1, 8'h01},
        '{1'b1, `FM_REG_AR + 8'd1,      8'hff},
        '{1'b1, `FM_REG_RR + 8'd1,      8'hff},
        '{1'b1, `FM_REG_PAN + 8'd1,     8'h80},
        '{1'b1, `FM_REG_KEYON,          8'h11}
    };

    fm_top dut0 (
        .rst        ( rst        ),
        .clk        ( clk        ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("error %0t: %s", $time, what);
            errors++;
        end
    endtask

    // one clk with inputs changed on the falling edge
    task automatic step(input logic hold);
        @(negedge clk);
        if (cen)
            ticks++;    // cen was high at the rising edge just passed
        cen = hold || !gated || ($urandom % 4 != 0);
    endtask

    task automatic bus_write(input wr_t w);
        if (w.poll)
            while (dout[7])
                step(1'b0);
        step(1'b1);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = w.ra;
        step(1'b1);
        addr = 2'b01;
        din  = w.data;
        step(1'b0);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_samples(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            step(1'b0);
            if (snd_sample)
                seen++;
        end
    endtask

    task automatic idle_outputs(input test_t t);
        int t0;
        int smps;
        int last;
        t0   = ticks;
        smps = 0;
        last = -1;
        while (ticks - t0 < t.win) begin
            step(1'b0);
            if (snd_sample) begin
                if (last >= 0)
                    check(ticks - last == `FM_NUM_CH,
                          $sformatf("snd_sample after %0d cen ticks", ticks - last));
                last = ticks;
                smps++;
                check(dout == 8'h00, $sformatf("dout %h after reset", dout));
                check(irq_n, "irq_n low after reset");
                check(snd_left == 0 && snd_right == 0,
                      $sformatf("sound %0d/%0d after reset", snd_left, snd_right));
            end
        end
        check(smps >= 3, $sformatf("only %0d snd_sample pulses", smps));
    endtask

    task automatic busy_timing(input test_t t);
        int t0;
        check(dout[7], "busy not set by a data write");
        t0 = ticks;
        while (dout[7] && ticks - t0 < t.win)
            step(1'b0);
        check(!dout[7] && ticks - t0 >= `FM_BUSY_CYCLES - 2
              && ticks - t0 <= `FM_BUSY_CYCLES + 2,
              $sformatf("busy lasted %0d cen ticks", ticks - t0));
    endtask

    task automatic timer_period(input test_t t);
        int  t0;
        int  dt;
        wr_t clr;
        t0 = ticks;
        while (dout[1:0] == 2'b00 && ticks - t0 < t.win)
            step(1'b0);
        dt = ticks - t0;
        check(dout[1:0] == t.flags, $sformatf("flags %b, expected %b", dout[1:0], t.flags));
        check(irq_n == t.irq, $sformatf("irq_n %b, expected %b", irq_n, t.irq));
        if (t.period != 0) begin
            // one sample of phase uncertainty
            check(dt >= t.period - `FM_NUM_CH && dt <= t.period + `FM_NUM_CH,
                  $sformatf("flag after %0d ticks, expected %0d", dt, t.period));
            clr.poll = 1'b1;
            clr.ra   = `FM_REG_TCTL;
            clr.data = {2'b00, t.flags, 4'b0000};
            bus_write(clr);
            step(1'b0);
            check(dout[1:0] == 2'b00 && irq_n,
                  $sformatf("after clear flags %b irq_n %b", dout[1:0], irq_n));
        end
    endtask

    task automatic voice_activity(input test_t t);
        int         t0;
        logic [1:0] seen;
        wr_t        off;
        t0   = ticks;
        seen = 2'b00;
        while (seen != t.act && ticks - t0 < t.win) begin
            step(1'b0);
            if (snd_sample) begin
                seen = seen | {snd_left != 0, snd_right != 0};
                check(t.act[1] || snd_left == 0, $sformatf("snd_left %0d", snd_left));
                check(t.act[0] || snd_right == 0, $sformatf("snd_right %0d", snd_right));
            end
        end
        check(seen == t.act, $sformatf("active sides %b, expected %b", seen, t.act));
        if (t.kind == K_VOICE_OFF) begin
            for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                off.poll = 1'b1;
                off.ra   = `FM_REG_KEYON;
                off.data = 8'(ch);  // key bit low
                bus_write(off);
            end
            wait_samples(REL_SMP);
            for (int s = 0; s < 4; s++) begin
                wait_samples(1);
                check(snd_left == 0 && snd_right == 0,
                      $sformatf("after key off %0d/%0d", snd_left, snd_right));
            end
        end
    endtask

    initial begin
        int err0;
        rst    = 1'b1;
        cen    = 1'b0;
        din    = 8'h00;
        addr   = 2'b00;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        gated  = 1'b0;
        ticks  = 0;
        errors = 0;
        passed = 0;
        cycles = 0;
        void'($urandom(32'h7581));
        limit = MARGIN + NUM_WR * 100;
        for (int i = 0; i < NUM_TESTS; i++)
            limit += 2 * tests[i].win;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            err0  = errors;
            gated = tests[i].kind == K_TIMER;
            for (int w = 0; w < tests[i].num; w++)
                bus_write(wr_tab[tests[i].first + w]);
            case (tests[i].kind)
                K_RESET: idle_outputs(tests[i]);
                K_BUSY:  busy_timing(tests[i]);
                K_TIMER: timer_period(tests[i]);
                default: voice_activity(tests[i]);
            endcase
            if (errors == err0) begin
                passed++;
                $display("test %0d %s: ok", i, names[i]);
            end else begin
                $display("test %0d %s: %0d errors", i, names[i], errors - err0);
            end
        end
        $display("%0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end
endmodule

/* fm_props.sv */
`include "fm_consts.svh"

module fm_props (
    input logic               clk,
    input logic               rst,
    input logic               cen,
    input logic [7:0]         din,
    input logic [1:0]         addr,
    input logic               cs_n,
    input logic               wr_n,
    input logic [7:0]         dout,
    input logic               irq_n,
    input logic signed [15:0] snd_right,
    input logic               snd_sample
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]            lat_addr;
    logic                  lat_part;
    logic [`FM_NUM_CH-1:0] pan_r;   // right pan per channel, seen from the bus
    logic [1:0]            quiet;   // samples since any right pan

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_addr <= 8'd0;
            lat_part <= 1'b0;
            pan_r    <= '0;
        end else if (cen && !cs_n && !wr_n) begin
            if (!addr[0]) begin
                lat_addr <= din;
                lat_part <= addr[1];
            end else if (!dout[7] && !lat_part) begin
                for (int i = 0; i < `FM_NUM_CH; i++)
                    if (lat_addr == `FM_REG_PAN + i)
                        pan_r[i] <= din[6];
            end
        end
    end

    // a sample in flight may still carry right pan, so wait three
    always_ff @(posedge clk) begin
        if (rst || pan_r != '0)
            quiet <= 2'd0;
        else if (snd_sample && quiet != 2'd3)
            quiet <= quiet + 1'b1;
    end

    irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
        !irq_n |-> dout[1:0] != 2'b00)
        else $error("irq_n low with no status flag set");

    sample_pulse: assert property (@(posedge clk) disable iff (rst)
        snd_sample |=> !snd_sample)
        else $error("snd_sample longer than one clk");

    dout_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(dout))
        else $error("dout has unknown bits");

    right_silent: assert property (@(posedge clk) disable iff (rst)
        quiet == 2'd3 |-> snd_right == 16'sd0)
        else $error("snd_right nonzero with no channel panned right");
endmodule

bind fm_top fm_props props0 (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( cen        ),
    .din        ( din        ),
    .addr       ( addr       ),
    .cs_n       ( cs_n       ),
    .wr_n       ( wr_n       ),
    .dout       ( dout       ),
    .irq_n      ( irq_n      ),
    .snd_right  ( snd_right  ),
    .snd_sample ( snd_sample )
);

/* fm_top.sv */
`include "fm_consts.svh"

module fm_top (
    input  logic               rst,
    input  logic               clk,
    input  logic               cen,
    input  logic [7:0]         din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    output logic [7:0]         dout,
    output logic               irq_n,
    output logic signed [15:0] snd_left,
    output logic signed [15:0] snd_right,
    output logic               snd_sample
);
    fm_timer_if tmr_if ();
    fm_chan_if  chn_if ();

    logic signed [`FM_SMP_W-1:0] smp;
    logic [1:0]                  smp_rl;
    logic                        smp_last;
    logic                        smp_en;

    fm_mmr u_mmr (
        .rst    ( rst       ),
        .clk    ( clk       ),
        .cen    ( cen       ),  // clk_en is cen
        .din    ( din       ),
        .addr   ( addr      ),
        .cs_n   ( cs_n      ),
        .wr_n   ( wr_n      ),
        .dout   ( dout      ),
        .tmr    ( tmr_if    ),
        .chn    ( chn_if    )
    );

    fm_timers u_timers (
        .rst    ( rst       ),
        .clk    ( clk       ),
        .tmr    ( tmr_if    ),
        .irq_n  ( irq_n     )
    );

    fm_voice u_voice (
        .rst      ( rst       ),
        .clk      ( clk       ),
        .chn      ( chn_if    ),
        .smp      ( smp       ),
        .smp_rl   ( smp_rl    ),
        .smp_last ( smp_last  ),
        .smp_en   ( smp_en    )
    );

    fm_mixer u_mixer (
        .rst        ( rst         ),
        .clk        ( clk         ),
        .smp        ( smp         ),
        .smp_rl     ( smp_rl      ),
        .smp_last   ( smp_last    ),
        .smp_en     ( smp_en      ),
        .snd_left   ( snd_left    ),
        .snd_right  ( snd_right   ),
        .snd_sample ( snd_sample  )
    );
endmodule

/* fm_mixer.sv */
`include "fm_consts.svh"

module fm_mixer (
    input  logic                        rst,
    input  logic                        clk,
    input  logic signed [`FM_SMP_W-1:0] smp,
    input  logic [1:0]                  smp_rl,
    input  logic                        smp_last,
    input  logic                        smp_en,
    output logic signed [15:0]          snd_left,
    output logic signed [15:0]          snd_right,
    output logic                        snd_sample
);
    localparam int SMP_W = `FM_SMP_W;
    localparam int ACC_W = SMP_W + 2;   // headroom for all slots

    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;
    logic signed [ACC_W-1:0] sum_l;
    logic signed [ACC_W-1:0] sum_r;

    // saturate back to sample width
    function automatic logic signed [SMP_W-1:0] clamp(input logic signed [ACC_W-1:0] v);
        logic [ACC_W-SMP_W:0] top;
        top = v[ACC_W-1:SMP_W-1];
        if (top == '0 || top == '1)
            return v[SMP_W-1:0];
        else
            return v[ACC_W-1] ? {1'b1, {(SMP_W-1){1'b0}}} : {1'b0, {(SMP_W-1){1'b1}}};
    endfunction

    always_comb begin
        sum_l = acc_l + (smp_rl[1] ? ACC_W'(smp) : '0);
        sum_r = acc_r + (smp_rl[0] ? ACC_W'(smp) : '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_l      <= '0;
            acc_r      <= '0;
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= smp_en && smp_last;
            if (smp_en && smp_last) begin
                snd_left  <= {clamp(sum_l), 4'd0};
                snd_right <= {clamp(sum_r), 4'd0};
                acc_l     <= '0;    // next sample starts fresh
                acc_r     <= '0;
            end else if (smp_en) begin
                acc_l <= sum_l;
                acc_r <= sum_r;
            end
        end
    end
endmodule

/* fm_voice.sv */
`include "fm_consts.svh"

module fm_voice (
    input  logic                        rst,
    input  logic                        clk,
    fm_chan_if.voice                    chn,
    output logic signed [`FM_SMP_W-1:0] smp,
    output logic [1:0]                  smp_rl,
    output logic                        smp_last,
    output logic                        smp_en
);
    localparam int NUM_CH  = `FM_NUM_CH;
    localparam int PHASE_W = `FM_PHASE_W;

    logic [PHASE_W-1:0] phase [NUM_CH];
    logic [7:0]         env   [NUM_CH];

    logic [PHASE_W-1:0] cur_phase;
    logic [PHASE_W-1:0] step;
    logic [7:0]         cur_env;
    logic [7:0]         env_next;
    logic [8:0]         env_up;
    logic [11:0]        tri_idx;
    logic signed [11:0] tri_wave;
    logic signed [8:0]  env_s;
    logic signed [20:0] prod;

    assign cur_phase = phase[chn.slot];
    assign cur_env   = env[chn.slot];
    assign step      = PHASE_W'(chn.fnum) << chn.block;

    // linear envelope
    assign env_up = {1'b0, cur_env} + {1'b0, chn.ar};

    always_comb begin
        if (chn.keyon)
            env_next = env_up[8] ? 8'hff : env_up[7:0];   // stop at 255
        else if (cur_env > chn.rr)
            env_next = cur_env - chn.rr;
        else
            env_next = 8'd0;
    end

    // fold the top phase bits into a triangle centred on zero
    assign tri_idx  = cur_phase[PHASE_W-1 -: 12];
    assign tri_wave = $signed({1'b0, tri_idx[11] ? ~tri_idx[10:0] : tri_idx[10:0]})
                      - 12'sd1024;
    assign env_s    = $signed({1'b0, cur_env});
    assign prod     = tri_wave * env_s;     // env 255 is just under unity

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                phase[i] <= '0;
                env[i]   <= '0;
            end
            smp      <= '0;
            smp_rl   <= '0;
            smp_last <= 1'b0;
            smp_en   <= 1'b0;
        end else begin
            smp_en <= chn.en;
            if (chn.en) begin
                phase[chn.slot] <= cur_phase + step;
                env[chn.slot]   <= env_next;
                smp             <= prod[19:8];
                smp_rl          <= chn.rl;
                smp_last        <= chn.slot == NUM_CH - 1;
            end
        end
    end
endmodule

/* fm_timers.sv */
module fm_timers (
    input  logic       rst,
    input  logic       clk,
    fm_timer_if.timers tmr,
    output logic       irq_n
);
    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] pre_b;      // B counts once per 16 ticks
    logic       ovf_a;
    logic       ovf_b;

    assign ovf_a = tmr.load_a && tmr.tick && cnt_a == 10'h3ff;
    assign ovf_b = tmr.load_b && tmr.tick && pre_b == 4'hf && cnt_b == 8'hff;

    always_ff @(posedge clk) begin
        if (rst)
            cnt_a <= '0;
        else if (!tmr.load_a || ovf_a)
            cnt_a <= tmr.value_a;       // hold or reload
        else if (tmr.tick)
            cnt_a <= cnt_a + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= '0;
            pre_b <= '0;
        end else if (!tmr.load_b) begin
            cnt_b <= tmr.value_b;
            pre_b <= '0;
        end else if (tmr.tick) begin
            pre_b <= pre_b + 1'b1;
            if (pre_b == 4'hf)
                cnt_b <= ovf_b ? tmr.value_b : cnt_b + 1'b1;
        end
    end

    // clear wins over a set in the same clk
    always_ff @(posedge clk) begin
        if (rst)
            tmr.flag_a <= 1'b0;
        else if (tmr.clr_a)
            tmr.flag_a <= 1'b0;
        else if (ovf_a && tmr.irq_en_a)
            tmr.flag_a <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            tmr.flag_b <= 1'b0;
        else if (tmr.clr_b)
            tmr.flag_b <= 1'b0;
        else if (ovf_b && tmr.irq_en_b)
            tmr.flag_b <= 1'b1;
    end

    assign irq_n = !(tmr.flag_a || tmr.flag_b);
endmodule

/* fm_mmr.sv */
`include "fm_consts.svh"

module fm_mmr import fm_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    fm_timer_if.mmr    tmr,
    fm_chan_if.mmr     chn
);
    localparam int NUM_CH = `FM_NUM_CH;
    localparam int BUSY_W = $clog2(`FM_BUSY_CYCLES + 1);

    logic                  write;
    logic                  addr_wr;
    logic                  data_wr;
    logic                  reg_wr;
    logic [7:0]            reg_addr;
    logic                  reg_part;    // addr[1] at address write
    fm_reg_u               wdata;
    logic [BUSY_W-1:0]     busy_cnt;
    logic                  busy;
    logic [`FM_SLOT_W-1:0] slot;

    logic [10:0]       fnum  [NUM_CH];
    logic [2:0]        block [NUM_CH];
    logic [1:0]        rl    [NUM_CH];
    logic [7:0]        ar    [NUM_CH];
    logic [7:0]        rr    [NUM_CH];
    logic [NUM_CH-1:0] key;

    assign write    = cen && !cs_n && !wr_n;
    assign addr_wr  = write && !addr[0];
    assign data_wr  = write && addr[0] && !busy;   // dropped while busy
    assign reg_wr   = data_wr && !reg_part;        // only part 0 is mapped
    assign wdata.raw = din;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_addr <= 8'd0;
            reg_part <= 1'b0;
        end else if (addr_wr) begin
            reg_addr <= din;
            reg_part <= addr[1];
        end
    end

    // busy counts down on cen ticks
    always_ff @(posedge clk) begin
        if (rst)
            busy_cnt <= '0;
        else if (data_wr)
            busy_cnt <= BUSY_W'(`FM_BUSY_CYCLES);
        else if (cen && busy)
            busy_cnt <= busy_cnt - 1'b1;
    end

    assign busy = busy_cnt != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            tmr.value_a  <= '0;
            tmr.value_b  <= '0;
            tmr.load_a   <= 1'b0;
            tmr.load_b   <= 1'b0;
            tmr.irq_en_a <= 1'b0;
            tmr.irq_en_b <= 1'b0;
            tmr.clr_a    <= 1'b0;
            tmr.clr_b    <= 1'b0;
        end else begin
            tmr.clr_a <= 1'b0;
            tmr.clr_b <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    `FM_REG_TA_HI: tmr.value_a[9:2] <= wdata.raw;
                    `FM_REG_TA_LO: tmr.value_a[1:0] <= wdata.raw[1:0];
                    `FM_REG_TB:    tmr.value_b      <= wdata.raw;
                    `FM_REG_TCTL: begin
                        tmr.load_a   <= wdata.tctl.load_a;
                        tmr.load_b   <= wdata.tctl.load_b;
                        tmr.irq_en_a <= wdata.tctl.irq_en_a;
                        tmr.irq_en_b <= wdata.tctl.irq_en_b;
                        tmr.clr_a    <= wdata.tctl.clr_a;
                        tmr.clr_b    <= wdata.tctl.clr_b;
                    end
                    default: ;
                endcase
            end
        end
    end

    // per-channel settings and key state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                fnum[i]  <= '0;
                block[i] <= '0;
                rl[i]    <= '0;
                ar[i]    <= '0;
                rr[i]    <= '0;
            end
            key <= '0;
        end else if (reg_wr) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (reg_addr == `FM_REG_FNUM_LO + i)
                    fnum[i][7:0] <= wdata.raw;
                if (reg_addr == `FM_REG_FNUM_HI + i) begin
                    block[i]      <= wdata.raw[5:3];
                    fnum[i][10:8] <= wdata.raw[2:0];
                end
                if (reg_addr == `FM_REG_PAN + i)
                    rl[i] <= wdata.raw[7:6];
                if (reg_addr == `FM_REG_AR + i)
                    ar[i] <= wdata.raw;
                if (reg_addr == `FM_REG_RR + i)
                    rr[i] <= wdata.raw;
                if (reg_addr == `FM_REG_KEYON && wdata.kon.ch == i)
                    key[i] <= wdata.kon.key;   // ch 3 matches nothing
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            slot <= '0;
        else if (cen)
            slot <= (slot == NUM_CH - 1) ? '0 : slot + 1'b1;
    end

    assign chn.slot  = slot;
    assign chn.fnum  = fnum[slot];
    assign chn.block = block[slot];
    assign chn.keyon = key[slot];
    assign chn.ar    = ar[slot];
    assign chn.rr    = rr[slot];
    assign chn.rl    = rl[slot];
    assign chn.en    = cen;

    assign tmr.tick = cen && slot == '0;   // start of each sample
    assign dout     = {busy, 5'd0, tmr.flag_b, tmr.flag_a};
endmodule

/* fm_chan_if.sv */
`include "fm_consts.svh"

interface fm_chan_if;
    logic [`FM_SLOT_W-1:0] slot;
    logic [10:0]           fnum;
    logic [2:0]            block;
    logic                  keyon;
    logic [7:0]            ar;      // attack step per sample
    logic [7:0]            rr;      // release step per sample
    logic [1:0]            rl;      // {left, right}
    logic                  en;

    // settings shown always belong to the current slot
    modport mmr (
        output slot, fnum, block, keyon, ar, rr, rl, en
    );

    modport voice (
        input  slot, fnum, block, keyon, ar, rr, rl, en
    );
endinterface

/* fm_timer_if.sv */
interface fm_timer_if;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic       load_a;     // run enable, counter held at value while low
    logic       load_b;
    logic       irq_en_a;
    logic       irq_en_b;
    logic       clr_a;      // one clk pulse
    logic       clr_b;
    logic       flag_a;
    logic       flag_b;
    logic       tick;       // once per sample

    modport mmr (
        output value_a, value_b, load_a, load_b, irq_en_a, irq_en_b,
        output clr_a, clr_b, tick,
        input  flag_a, flag_b
    );

    modport timers (
        input  value_a, value_b, load_a, load_b, irq_en_a, irq_en_b,
        input  clr_a, clr_b, tick,
        output flag_a, flag_b
    );
endinterface

/* fm_pkg.sv */
package fm_pkg;

    // timer control byte at FM_REG_TCTL
    typedef struct packed {
        logic [1:0] unused;
        logic       clr_b;
        logic       clr_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } fm_tctl_t;

    // key-on byte at FM_REG_KEYON
    typedef struct packed {
        logic [2:0] unused_hi;
        logic       key;
        logic [1:0] unused_lo;
        logic [1:0] ch;         // channel select
    } fm_keyon_t;

    typedef union packed {
        logic [7:0] raw;
        fm_tctl_t   tctl;
        fm_keyon_t  kon;
    } fm_reg_u;

endpackage

/* fm_consts.svh */
`ifndef FM_CONSTS_SVH
`define FM_CONSTS_SVH

// voice engine
`define FM_NUM_CH       3       // one slot per channel in each sample
`define FM_SLOT_W       2
`define FM_PHASE_W      20
`define FM_SMP_W        12      // signed slot sample

// bus handshake
`define FM_BUSY_CYCLES  32      // cen ticks after a data write

// register map, per-channel registers are base + channel
`define FM_REG_TA_HI    8'h24   // timer A bits 9:2
`define FM_REG_TA_LO    8'h25   // timer A bits 1:0
`define FM_REG_TB       8'h26
`define FM_REG_TCTL     8'h27
`define FM_REG_KEYON    8'h28
`define FM_REG_AR       8'h50
`define FM_REG_RR       8'h80
`define FM_REG_FNUM_LO  8'ha0
`define FM_REG_FNUM_HI  8'ha4   // block in 5:3, fnum msbs in 2:0
`define FM_REG_PAN      8'hb4   // bit 7 left, bit 6 right

`endif
